//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_session_manager
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(wildcard design/*.sv) $(wildcard tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/host_table.sv
// per-host configuration memory
// target company id, id length and initiator role, registered read

`timescale 1ns/1ps
`default_nettype none

module host_table #(
	parameter int HOST_W     = 3,
	parameter int COMP_ID_W  = 64,
	parameter int COMP_LEN_W = 4
) (
	input  wire                   clk,
	input  wire                   cfg_we_i,
	input  wire [HOST_W-1:0]      cfg_host_i,
	input  wire [COMP_ID_W-1:0]   cfg_comp_id_i,
	input  wire [COMP_LEN_W-1:0]  cfg_comp_len_i,
	input  wire                   cfg_initiator_i,
	input  wire [HOST_W-1:0]      rd_host_i,
	output logic [COMP_ID_W-1:0]  comp_id_o,
	output logic [COMP_LEN_W-1:0] comp_len_o,
	output logic                  initiator_o
);

	localparam int N_HOST = 1 << HOST_W;

	logic [COMP_ID_W-1:0]  id_mem   [N_HOST];
	logic [COMP_LEN_W-1:0] len_mem  [N_HOST];
	logic                  init_mem [N_HOST];

	always_ff @(posedge clk) begin
		if (cfg_we_i) begin
			id_mem[cfg_host_i]   <= cfg_comp_id_i;
			len_mem[cfg_host_i]  <= cfg_comp_len_i;
			init_mem[cfg_host_i] <= cfg_initiator_i;
		end
		comp_id_o   <= id_mem[rd_host_i]; // old data on a same-edge write
		comp_len_o  <= len_mem[rd_host_i];
		initiator_o <= init_mem[rd_host_i];
	end

endmodule

`default_nettype wire

//--- design/session_fsm.sv
// event capture and session decision logic
// one event per cycle, priority message > connect > timeout

`timescale 1ns/1ps
`default_nettype none

module session_fsm #(
	parameter int HOST_W = 3
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          msg_valid_i,
	input  session_pkg::msg_type_t       msg_type_i,
	input  session_pkg::validity_t       validity_i,
	input  wire                          connect_i,
	input  wire                          timeout_i,
	input  wire [HOST_W-1:0]             host_i,
	input  session_pkg::session_state_e  state_i,
	input  wire                          initiator_i,
	output logic                         state_we_o,
	output logic [HOST_W-1:0]            state_host_o,
	output session_pkg::session_state_e  next_state_o,
	output session_pkg::action_e         action_o,
	output logic [HOST_W-1:0]            action_host_o
);

	import session_pkg::*;

	typedef enum logic [1:0] {
		EV_NONE,
		EV_MSG,
		EV_CONNECT,
		EV_TIMEOUT
	} event_e;

	event_e            ev_kind;
	msg_type_t         ev_type;
	validity_t         ev_val;
	logic [HOST_W-1:0] ev_host;

	logic fatal, garbled, seq_high, valid;
	logic is_logon, is_logout, is_hb, is_seq_fix;

	// capture stage drops lower-priority events in the same cycle
	always_ff @(posedge clk) begin
		if (rst)
			ev_kind <= EV_NONE;
		else if (msg_valid_i)
			ev_kind <= EV_MSG;
		else if (connect_i)
			ev_kind <= EV_CONNECT;
		else if (timeout_i)
			ev_kind <= EV_TIMEOUT;
		else
			ev_kind <= EV_NONE;
	end

	always_ff @(posedge clk) begin
		ev_type <= msg_type_i;
		ev_val  <= validity_i;
		ev_host <= host_i;
	end

	assign valid    = (ev_val == VAL_VALID);
	assign garbled  = (ev_val == VAL_GARBLED);
	assign seq_high = (ev_val == VAL_SEQ_HIGH);
	assign fatal    = !(valid || garbled || seq_high); // seq low, invalid, unknown

	assign is_logon   = (ev_type == MSG_LOGON);
	assign is_logout  = (ev_type == MSG_LOGOUT);
	assign is_hb      = (ev_type == MSG_HEARTBEAT);
	assign is_seq_fix = (ev_type == MSG_GAP_FILL) || (ev_type == MSG_SEQ_RESET);

	always_comb begin
		next_state_o = state_i;
		action_o     = ACT_NONE;
		case (ev_kind)
			EV_MSG: begin
				if (fatal) begin
					action_o     = ACT_DISCONNECT;
					next_state_o = ST_DISCONNECTED;
				end else begin
					case (state_i)
						ST_CONNECTED, ST_LOGON_SENT: begin
							if (is_logon && valid) begin
								next_state_o = ST_NORMAL;
								if (state_i == ST_CONNECTED)
									action_o = ACT_SEND_LOGON; // acceptor answers
							end else if (is_logon && seq_high) begin
								action_o     = ACT_SEND_RESEND_REQ;
								next_state_o = ST_SENT_RESEND_REQ;
							end else begin
								action_o     = ACT_DISCONNECT;
								next_state_o = ST_DISCONNECTED;
							end
						end
						ST_NORMAL, ST_SENT_HEARTBEAT: begin
							if (garbled) begin
								action_o = ACT_IGNORE;
							end else if (seq_high) begin
								action_o     = ACT_SEND_RESEND_REQ;
								next_state_o = ST_SENT_RESEND_REQ;
							end else if (is_logout) begin
								action_o     = ACT_SEND_LOGOUT;
								next_state_o = ST_DISCONNECTED;
							end else if (is_hb) begin
								action_o     = ACT_SEND_HEARTBEAT;
								next_state_o = ST_SENT_HEARTBEAT;
							end else begin
								next_state_o = ST_NORMAL; // any other traffic
							end
						end
						ST_SENT_RESEND_REQ: begin
							if (garbled)
								action_o = ACT_IGNORE;
							else if (is_seq_fix)
								action_o = ACT_SEQ_UPDATE;
							else if (seq_high)
								action_o = ACT_SEND_RESEND_REQ;
							else
								next_state_o = ST_NORMAL; // gap closed
						end
						default: ; // nothing to do when disconnected
					endcase
				end
			end
			EV_CONNECT: begin
				if (initiator_i) begin
					action_o     = ACT_SEND_LOGON;
					next_state_o = ST_LOGON_SENT;
				end else begin
					next_state_o = ST_CONNECTED;
				end
			end
			EV_TIMEOUT: begin
				if (state_i == ST_DISCONNECTED) begin
					action_o = ACT_NONE;
				end else if (state_i == ST_SENT_HEARTBEAT ||
						(initiator_i && state_i == ST_LOGON_SENT)) begin
					action_o     = ACT_DISCONNECT; // peer went silent
					next_state_o = ST_DISCONNECTED;
				end else begin
					action_o     = ACT_SEND_HEARTBEAT;
					next_state_o = ST_SENT_HEARTBEAT;
				end
			end
			default: ;
		endcase
	end

	assign state_we_o    = (ev_kind != EV_NONE);
	assign state_host_o  = ev_host;
	assign action_host_o = ev_host;

endmodule

`default_nettype wire

//--- design/session_manager.sv
// session manager top level
// host table, session table, decision and output stages

`timescale 1ns/1ps
`default_nettype none

module session_manager #(
	parameter int HOST_W     = 3,
	parameter int COMP_ID_W  = 64,
	parameter int COMP_LEN_W = 4
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     cfg_we_i,
	input  wire [HOST_W-1:0]        cfg_host_i,
	input  wire [COMP_ID_W-1:0]     cfg_comp_id_i,
	input  wire [COMP_LEN_W-1:0]    cfg_comp_len_i,
	input  wire                     cfg_initiator_i,
	input  wire                     msg_valid_i,
	input  session_pkg::msg_type_t  msg_type_i,
	input  session_pkg::validity_t  validity_i,
	input  wire                     connect_i,
	input  wire                     timeout_i,
	input  wire [HOST_W-1:0]        host_i,
	output logic                    disconnect_o,
	output logic [HOST_W-1:0]       disconnect_host_o,
	output logic                    ignore_o,
	output logic                    seq_update_o,
	output logic [HOST_W-1:0]       seq_host_o,
	output logic                    initiate_msg_o,
	output session_pkg::msg_type_t  msg_type_o,
	output logic [COMP_ID_W-1:0]    target_comp_id_o,
	output logic [COMP_LEN_W-1:0]   comp_id_len_o
);

	import session_pkg::*;

	logic [COMP_ID_W-1:0]  comp_id;
	logic [COMP_LEN_W-1:0] comp_len;
	logic                  initiator;
	session_state_e        cur_state;
	session_state_e        next_state;
	logic                  state_we;
	logic [HOST_W-1:0]     state_host;
	action_e               action;
	logic [HOST_W-1:0]     action_host;

	host_table #(
		.HOST_W(HOST_W), .COMP_ID_W(COMP_ID_W), .COMP_LEN_W(COMP_LEN_W)
	) u_host_table (
		.clk(clk), .cfg_we_i(cfg_we_i), .cfg_host_i(cfg_host_i),
		.cfg_comp_id_i(cfg_comp_id_i), .cfg_comp_len_i(cfg_comp_len_i),
		.cfg_initiator_i(cfg_initiator_i), .rd_host_i(host_i),
		.comp_id_o(comp_id), .comp_len_o(comp_len), .initiator_o(initiator)
	);

	session_table #(.HOST_W(HOST_W)) u_session_table (
		.clk(clk), .rst(rst), .rd_host_i(host_i), .state_o(cur_state),
		.we_i(state_we), .wr_host_i(state_host), .state_i(next_state)
	);

	session_fsm #(.HOST_W(HOST_W)) u_session_fsm (
		.clk(clk), .rst(rst), .msg_valid_i(msg_valid_i), .msg_type_i(msg_type_i),
		.validity_i(validity_i), .connect_i(connect_i), .timeout_i(timeout_i),
		.host_i(host_i), .state_i(cur_state), .initiator_i(initiator),
		.state_we_o(state_we), .state_host_o(state_host), .next_state_o(next_state),
		.action_o(action), .action_host_o(action_host)
	);

	session_output #(
		.HOST_W(HOST_W), .COMP_ID_W(COMP_ID_W), .COMP_LEN_W(COMP_LEN_W)
	) u_session_output (
		.clk(clk), .rst(rst), .action_i(action), .action_host_i(action_host),
		.comp_id_i(comp_id), .comp_len_i(comp_len),
		.disconnect_o(disconnect_o), .disconnect_host_o(disconnect_host_o),
		.ignore_o(ignore_o), .seq_update_o(seq_update_o), .seq_host_o(seq_host_o),
		.initiate_msg_o(initiate_msg_o), .msg_type_o(msg_type_o),
		.target_comp_id_o(target_comp_id_o), .comp_id_len_o(comp_id_len_o)
	);

endmodule

`default_nettype wire

//--- design/session_output.sv
// output stage pipelining the action and host table data
// then mapping them onto strobes and message order

`timescale 1ns/1ps
`default_nettype none

module session_output #(
	parameter int HOST_W     = 3,
	parameter int COMP_ID_W  = 64,
	parameter int COMP_LEN_W = 4
) (
	input  wire                     clk,
	input  wire                     rst,
	input  session_pkg::action_e    action_i,
	input  wire [HOST_W-1:0]        action_host_i,
	input  wire [COMP_ID_W-1:0]     comp_id_i,
	input  wire [COMP_LEN_W-1:0]    comp_len_i,
	output logic                    disconnect_o,
	output logic [HOST_W-1:0]       disconnect_host_o,
	output logic                    ignore_o,
	output logic                    seq_update_o,
	output logic [HOST_W-1:0]       seq_host_o,
	output logic                    initiate_msg_o,
	output session_pkg::msg_type_t  msg_type_o,
	output logic [COMP_ID_W-1:0]    target_comp_id_o,
	output logic [COMP_LEN_W-1:0]   comp_id_len_o
);

	import session_pkg::*;

	action_e               act_q;
	logic [HOST_W-1:0]     host_q;
	logic [COMP_ID_W-1:0]  id_q;
	logic [COMP_LEN_W-1:0] len_q;
	logic                  send;
	msg_type_t             send_type;

	always_ff @(posedge clk) begin
		if (rst)
			act_q <= ACT_NONE;
		else
			act_q <= action_i;
	end

	// host table data belongs to the decided event in this cycle only
	always_ff @(posedge clk) begin
		host_q <= action_host_i;
		id_q   <= comp_id_i;
		len_q  <= comp_len_i;
	end

	always_comb begin
		send      = 1'b1;
		send_type = MSG_HEARTBEAT;
		case (act_q)
			ACT_SEND_LOGON:      send_type = MSG_LOGON;
			ACT_SEND_LOGOUT:     send_type = MSG_LOGOUT;
			ACT_SEND_HEARTBEAT:  send_type = MSG_HEARTBEAT;
			ACT_SEND_RESEND_REQ: send_type = MSG_RESEND_REQ;
			default:             send = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			disconnect_o   <= 1'b0;
			ignore_o       <= 1'b0;
			seq_update_o   <= 1'b0;
			initiate_msg_o <= 1'b0;
		end else begin
			disconnect_o   <= (act_q == ACT_DISCONNECT);
			ignore_o       <= (act_q == ACT_IGNORE);
			seq_update_o   <= (act_q == ACT_SEQ_UPDATE);
			initiate_msg_o <= send;
		end
	end

	// qualifying values hold between strobes
	always_ff @(posedge clk) begin
		if (act_q == ACT_DISCONNECT)
			disconnect_host_o <= host_q;
		if (act_q == ACT_SEQ_UPDATE)
			seq_host_o <= host_q;
		if (send) begin
			msg_type_o       <= send_type;
			target_comp_id_o <= id_q;
			comp_id_len_o    <= len_q;
		end
	end

endmodule

`default_nettype wire

//--- design/session_pkg.sv
// shared types and codes for the session manager
// message and validity codes, session states, actions

`default_nettype none

package session_pkg;

	// received or ordered message type
	typedef logic [3:0] msg_type_t;

	localparam msg_type_t MSG_LOGON      = 4'd1;
	localparam msg_type_t MSG_LOGOUT     = 4'd2;
	localparam msg_type_t MSG_HEARTBEAT  = 4'd3;
	localparam msg_type_t MSG_RESEND_REQ = 4'd4;
	localparam msg_type_t MSG_GAP_FILL   = 4'd5;
	localparam msg_type_t MSG_SEQ_RESET  = 4'd6;
	localparam msg_type_t MSG_APP        = 4'd7; // unknown codes behave the same

	// result of the receive checks
	typedef logic [3:0] validity_t;

	localparam validity_t VAL_VALID    = 4'd0;
	localparam validity_t VAL_GARBLED  = 4'd1;
	localparam validity_t VAL_SEQ_HIGH = 4'd2;
	localparam validity_t VAL_SEQ_LOW  = 4'd3;
	localparam validity_t VAL_INVALID  = 4'd4; // also any code above

	typedef enum logic [2:0] {
		ST_DISCONNECTED    = 3'd0,
		ST_CONNECTED       = 3'd1, // acceptor waiting for logon
		ST_LOGON_SENT      = 3'd2,
		ST_NORMAL          = 3'd3,
		ST_SENT_HEARTBEAT  = 3'd4,
		ST_SENT_RESEND_REQ = 3'd5
	} session_state_e;

	typedef enum logic [2:0] {
		ACT_NONE            = 3'd0,
		ACT_DISCONNECT      = 3'd1,
		ACT_IGNORE          = 3'd2,
		ACT_SEQ_UPDATE      = 3'd3,
		ACT_SEND_LOGON      = 3'd4,
		ACT_SEND_LOGOUT     = 3'd5,
		ACT_SEND_HEARTBEAT  = 3'd6,
		ACT_SEND_RESEND_REQ = 3'd7
	} action_e;

endpackage

`default_nettype wire

//--- design/session_table.sv
// per-host session state registers
// registered read with write-to-read bypass

`timescale 1ns/1ps
`default_nettype none

module session_table #(
	parameter int HOST_W = 3
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire [HOST_W-1:0]             rd_host_i,
	output session_pkg::session_state_e  state_o,
	input  wire                          we_i,
	input  wire [HOST_W-1:0]             wr_host_i,
	input  session_pkg::session_state_e  state_i
);

	import session_pkg::*;

	localparam int N_HOST = 1 << HOST_W;

	session_state_e states [N_HOST];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < N_HOST; i++)
				states[i] <= ST_DISCONNECTED;
			state_o <= ST_DISCONNECTED;
		end else begin
			if (we_i)
				states[wr_host_i] <= state_i;
			// forward the write so back-to-back events see the new state
			if (we_i && wr_host_i == rd_host_i)
				state_o <= state_i;
			else
				state_o <= states[rd_host_i];
		end
	end

endmodule

`default_nettype wire

//--- tests/session_assertions.sv
// concurrent assertions on the session manager output strobes
// bound into session_manager from the testbench

`timescale 1ns/1ps
`default_nettype none

module session_assertions (
	input wire       clk,
	input wire       rst,
	input wire       disconnect_o,
	input wire       ignore_o,
	input wire       seq_update_o,
	input wire       initiate_msg_o,
	input wire [3:0] msg_type_o
);

	import session_pkg::*;

	int fail_count = 0; // read by the testbench at the end

	a_one_strobe: assert property (@(posedge clk) disable iff (rst)
		$onehot0({disconnect_o, ignore_o, seq_update_o, initiate_msg_o}))
	else begin
		$error("more than one output strobe high in one cycle");
		fail_count++;
	end

	// only four message kinds are ever ordered
	a_order_type: assert property (@(posedge clk) disable iff (rst)
		initiate_msg_o |-> (msg_type_o == MSG_LOGON || msg_type_o == MSG_LOGOUT ||
			msg_type_o == MSG_HEARTBEAT || msg_type_o == MSG_RESEND_REQ))
	else begin
		$error("message order with a type that is never sent");
		fail_count++;
	end

	a_reset_clear: assert property (@(posedge clk)
		rst |=> !(disconnect_o || ignore_o || seq_update_o || initiate_msg_o))
	else begin
		$error("output strobe high in the cycle after reset");
		fail_count++;
	end

endmodule

`default_nettype wire

//--- tests/session_checker.sv
// reference model of the per-host session rules
// predicts outputs two edges after each event and compares them

`timescale 1ns/1ps
`default_nettype none

module session_checker #(
	parameter int HOST_W     = 3,
	parameter int COMP_ID_W  = 64,
	parameter int COMP_LEN_W = 4
) (
	input wire                  clk,
	input wire                  rst,
	input wire                  cfg_we_i,
	input wire [HOST_W-1:0]     cfg_host_i,
	input wire [COMP_ID_W-1:0]  cfg_comp_id_i,
	input wire [COMP_LEN_W-1:0] cfg_comp_len_i,
	input wire                  cfg_initiator_i,
	input wire                  msg_valid_i,
	input wire [3:0]            msg_type_i,
	input wire [3:0]            validity_i,
	input wire                  connect_i,
	input wire                  timeout_i,
	input wire [HOST_W-1:0]     host_i,
	input wire                  disconnect_o,
	input wire [HOST_W-1:0]     disconnect_host_o,
	input wire                  ignore_o,
	input wire                  seq_update_o,
	input wire [HOST_W-1:0]     seq_host_o,
	input wire                  initiate_msg_o,
	input wire [3:0]            msg_type_o,
	input wire [COMP_ID_W-1:0]  target_comp_id_o,
	input wire [COMP_LEN_W-1:0] comp_id_len_o
);

	import session_pkg::*;

	localparam int N_HOST = 1 << HOST_W;

	session_state_e        st     [N_HOST];
	logic                  init_m [N_HOST];
	logic [COMP_ID_W-1:0]  id_m   [N_HOST];
	logic [COMP_LEN_W-1:0] len_m  [N_HOST];

	// expected action pipeline with index 2 due now
	action_e               exp_act  [3];
	logic [HOST_W-1:0]     exp_host [3];
	logic [COMP_ID_W-1:0]  exp_id   [3];
	logic [COMP_LEN_W-1:0] exp_len  [3];

	int  errors = 0;
	int  checks = 0;
	int  events = 0;
	bit  armed  = 0;

	function automatic action_e decide(input int kind, input session_state_e s, input bit ini,
			input msg_type_t t, input validity_t v, output session_state_e ns);
		action_e a;
		bit      is_fatal;
		a  = ACT_NONE;
		ns = s;
		is_fatal = (v == VAL_SEQ_LOW) || (v >= VAL_INVALID);
		if (kind == 1) begin
			if (is_fatal) begin
				a  = ACT_DISCONNECT;
				ns = ST_DISCONNECTED;
			end else if (s == ST_CONNECTED || s == ST_LOGON_SENT) begin
				if (t == MSG_LOGON && v == VAL_VALID) begin
					ns = ST_NORMAL;
					a  = (s == ST_CONNECTED) ? ACT_SEND_LOGON : ACT_NONE;
				end else if (t == MSG_LOGON && v == VAL_SEQ_HIGH) begin
					a  = ACT_SEND_RESEND_REQ;
					ns = ST_SENT_RESEND_REQ;
				end else begin
					a  = ACT_DISCONNECT;
					ns = ST_DISCONNECTED;
				end
			end else if (s == ST_NORMAL || s == ST_SENT_HEARTBEAT) begin
				if (v == VAL_GARBLED) a = ACT_IGNORE;
				else if (v == VAL_SEQ_HIGH) begin
					a  = ACT_SEND_RESEND_REQ;
					ns = ST_SENT_RESEND_REQ;
				end else if (t == MSG_LOGOUT) begin
					a  = ACT_SEND_LOGOUT;
					ns = ST_DISCONNECTED;
				end else if (t == MSG_HEARTBEAT) begin
					a  = ACT_SEND_HEARTBEAT;
					ns = ST_SENT_HEARTBEAT;
				end else if (s == ST_SENT_HEARTBEAT)
					ns = ST_NORMAL; // peer is alive again
			end else if (s == ST_SENT_RESEND_REQ) begin
				if (v == VAL_GARBLED) a = ACT_IGNORE;
				else if (t == MSG_GAP_FILL || t == MSG_SEQ_RESET) a = ACT_SEQ_UPDATE;
				else if (v == VAL_SEQ_HIGH) a = ACT_SEND_RESEND_REQ;
				else ns = ST_NORMAL;
			end
		end else if (kind == 2) begin
			a  = ini ? ACT_SEND_LOGON : ACT_NONE;
			ns = ini ? ST_LOGON_SENT : ST_CONNECTED;
		end else if (kind == 3 && s != ST_DISCONNECTED) begin
			if (s == ST_SENT_HEARTBEAT || (ini && s == ST_LOGON_SENT)) begin
				a  = ACT_DISCONNECT;
				ns = ST_DISCONNECTED;
			end else begin
				a  = ACT_SEND_HEARTBEAT;
				ns = ST_SENT_HEARTBEAT;
			end
		end
		return a;
	endfunction

	function automatic msg_type_t order_type(input action_e a);
		case (a)
			ACT_SEND_LOGON:  return MSG_LOGON;
			ACT_SEND_LOGOUT: return MSG_LOGOUT;
			ACT_SEND_RESEND_REQ: return MSG_RESEND_REQ;
			default:         return MSG_HEARTBEAT;
		endcase
	endfunction

	task automatic mismatch(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		errors++;
	endtask

	always @(posedge clk) begin
		int             kind;
		session_state_e ns;
		if (rst) begin
			for (int i = 0; i < N_HOST; i++)
				st[i] = ST_DISCONNECTED;
			for (int k = 0; k < 3; k++)
				exp_act[k] = ACT_NONE;
			armed = 1;
		end else begin
			for (int k = 2; k > 0; k--) begin
				exp_act[k]  = exp_act[k-1];
				exp_host[k] = exp_host[k-1];
				exp_id[k]   = exp_id[k-1];
				exp_len[k]  = exp_len[k-1];
			end
			kind = msg_valid_i ? 1 : connect_i ? 2 : timeout_i ? 3 : 0;
			exp_act[0]  = ACT_NONE;
			exp_host[0] = host_i;
			exp_id[0]   = id_m[host_i];
			exp_len[0]  = len_m[host_i];
			if (kind != 0) begin
				events++;
				exp_act[0] = decide(kind, st[host_i], init_m[host_i], msg_type_i, validity_i, ns);
				st[host_i] = ns;
			end
		end
		// table read on this edge still saw the old entry
		if (cfg_we_i) begin
			id_m[cfg_host_i]   = cfg_comp_id_i;
			len_m[cfg_host_i]  = cfg_comp_len_i;
			init_m[cfg_host_i] = cfg_initiator_i;
		end
	end

	always @(negedge clk) begin
		action_e a;
		bit      snd;
		if (armed && !rst) begin
			checks++;
			a   = exp_act[2];
			snd = (a == ACT_SEND_LOGON || a == ACT_SEND_LOGOUT ||
				a == ACT_SEND_HEARTBEAT || a == ACT_SEND_RESEND_REQ);
			if (disconnect_o !== (a == ACT_DISCONNECT))
				mismatch($sformatf("disconnect_o %b, expected action %s", disconnect_o, a.name()));
			else if (disconnect_o && disconnect_host_o !== exp_host[2])
				mismatch($sformatf("disconnect host %0d, expected %0d",
					disconnect_host_o, exp_host[2]));
			if (ignore_o !== (a == ACT_IGNORE))
				mismatch($sformatf("ignore_o %b, expected action %s", ignore_o, a.name()));
			if (seq_update_o !== (a == ACT_SEQ_UPDATE))
				mismatch($sformatf("seq_update_o %b, expected action %s", seq_update_o, a.name()));
			else if (seq_update_o && seq_host_o !== exp_host[2])
				mismatch($sformatf("seq host %0d, expected %0d", seq_host_o, exp_host[2]));
			if (initiate_msg_o !== snd)
				mismatch($sformatf("initiate_msg_o %b, expected action %s",
					initiate_msg_o, a.name()));
			else if (snd && (msg_type_o !== order_type(a) || target_comp_id_o !== exp_id[2] ||
					comp_id_len_o !== exp_len[2]))
				mismatch($sformatf("order type %0d id %h len %0d, expected %0d %h %0d",
					msg_type_o, target_comp_id_o, comp_id_len_o,
					order_type(a), exp_id[2], exp_len[2]));
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_session_manager.sv
// testbench for the session manager
// clock, reset, host configuration, directed and random events, report

`timescale 1ns/1ps
`default_nettype none

module tb_session_manager;

	import session_pkg::*;

	localparam int HOST_W      = 3; // top level defaults
	localparam int COMP_ID_W   = 64;
	localparam int COMP_LEN_W  = 4;
	localparam int N_HOST      = 1 << HOST_W;
	localparam int LAT_TIMEOUT = 8;
	localparam int SEED        = 44811;

	logic clk, rst;
	logic cfg_we_i, cfg_initiator_i;
	logic [HOST_W-1:0] cfg_host_i, host_i;
	logic [COMP_ID_W-1:0] cfg_comp_id_i;
	logic [COMP_LEN_W-1:0] cfg_comp_len_i;
	logic msg_valid_i, connect_i, timeout_i;
	msg_type_t msg_type_i;
	validity_t validity_i;
	logic disconnect_o, ignore_o, seq_update_o, initiate_msg_o;
	logic [HOST_W-1:0] disconnect_host_o, seq_host_o;
	msg_type_t msg_type_o;
	logic [COMP_ID_W-1:0] target_comp_id_o;
	logic [COMP_LEN_W-1:0] comp_id_len_o;

	int timeouts = 0;
	int last_bad = 0;

	session_manager dut (.*);

	session_checker #(.HOST_W(HOST_W), .COMP_ID_W(COMP_ID_W), .COMP_LEN_W(COMP_LEN_W))
		chk (.*);

	bind session_manager session_assertions u_assertions (
		.clk(clk), .rst(rst), .disconnect_o(disconnect_o), .ignore_o(ignore_o),
		.seq_update_o(seq_update_o), .initiate_msg_o(initiate_msg_o),
		.msg_type_o(msg_type_o)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic int bad_count();
		return chk.errors + timeouts + dut.u_assertions.fail_count;
	endfunction

	task automatic drive_event(input logic mv, input msg_type_t t, input validity_t v,
			input logic cn, input logic to, input logic [HOST_W-1:0] h);
		@(posedge clk);
		#1;
		msg_valid_i = mv;
		msg_type_i  = t;
		validity_i  = v;
		connect_i   = cn;
		timeout_i   = to;
		host_i      = h;
		@(posedge clk);
		#1;
		msg_valid_i = 1'b0;
		connect_i   = 1'b0;
		timeout_i   = 1'b0;
	endtask

	task automatic send_msg(input logic [HOST_W-1:0] h, input msg_type_t t, input validity_t v);
		drive_event(1'b1, t, v, 1'b0, 1'b0, h);
	endtask

	task automatic send_connect(input logic [HOST_W-1:0] h);
		drive_event(1'b0, MSG_APP, VAL_VALID, 1'b1, 1'b0, h);
	endtask

	task automatic send_timeout(input logic [HOST_W-1:0] h);
		drive_event(1'b0, MSG_APP, VAL_VALID, 1'b0, 1'b1, h);
	endtask

	// 0 disconnect, 1 ignore, 2 seq update, 3 message order
	task automatic wait_strobe(input int which, input string what);
		bit seen;
		seen = 0;
		for (int i = 0; i < LAT_TIMEOUT && !seen; i++) begin
			@(posedge clk);
			#1;
			case (which)
				0: seen = disconnect_o;
				1: seen = ignore_o;
				2: seen = seq_update_o;
				default: seen = initiate_msg_o;
			endcase
		end
		if (!seen) begin
			$display("timeout: no %s within %0d cycles at %0t ns", what, LAT_TIMEOUT, $time);
			timeouts++;
		end
	endtask

	task automatic drain();
		repeat (4) @(posedge clk);
		#1;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %s", name, (bad_count() == last_bad) ? "ok" : "mismatches seen");
		last_bad = bad_count();
	endtask

	task automatic configure_hosts();
		for (int h = 0; h < N_HOST; h++) begin
			@(posedge clk);
			#1;
			cfg_we_i        = 1'b1;
			cfg_host_i      = h[HOST_W-1:0];
			cfg_comp_id_i   = {$urandom, $urandom};
			cfg_comp_len_i  = COMP_LEN_W'($urandom);
			// host 0 initiates and host 1 accepts for the directed tests
			cfg_initiator_i = (h == 0) ? 1'b1 : (h == 1) ? 1'b0 : 1'($urandom);
		end
		@(posedge clk);
		#1;
		cfg_we_i = 1'b0;
	endtask

	task automatic random_mix(input int n);
		logic [HOST_W-1:0] h;
		int r;
		h = '0;
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#1;
			r = $urandom % 100;
			if ($urandom % 10 >= 3)
				h = HOST_W'($urandom); // else repeat the host back to back
			host_i      = h;
			msg_type_i  = 4'($urandom % 9);
			validity_i  = ($urandom % 2) ? VAL_VALID : 4'(1 + $urandom % 5);
			msg_valid_i = (r < 40) || (r >= 70 && r < 80 && $urandom % 2);
			connect_i   = (r >= 40 && r < 55) || (r >= 70 && r < 80 && $urandom % 2);
			timeout_i   = (r >= 55 && r < 80);
		end
		@(posedge clk);
		#1;
		msg_valid_i = 1'b0;
		connect_i   = 1'b0;
		timeout_i   = 1'b0;
		drain();
	endtask

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		cfg_we_i = 1'b0;
		cfg_host_i = '0;
		cfg_comp_id_i = '0;
		cfg_comp_len_i = '0;
		cfg_initiator_i = 1'b0;
		msg_valid_i = 1'b0;
		msg_type_i = MSG_APP;
		validity_i = VAL_VALID;
		connect_i = 1'b0;
		timeout_i = 1'b0;
		host_i = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		configure_hosts();

		send_connect(0);
		wait_strobe(3, "logon order");
		send_msg(0, MSG_LOGON, VAL_VALID);
		drain();
		send_msg(0, MSG_HEARTBEAT, VAL_VALID);
		wait_strobe(3, "heartbeat order");
		end_test("initiator_connect");

		send_connect(1);
		drain();
		send_msg(1, MSG_LOGON, VAL_VALID);
		wait_strobe(3, "logon order");
		send_connect(1);
		send_msg(1, MSG_APP, VAL_VALID);
		wait_strobe(0, "disconnect");
		end_test("acceptor_connect");

		send_connect(0);
		send_msg(0, MSG_LOGON, VAL_VALID);
		send_timeout(0);
		wait_strobe(3, "heartbeat order");
		send_timeout(0);
		wait_strobe(0, "disconnect");
		send_timeout(0);
		drain();
		end_test("timeouts");

		send_connect(0);
		send_msg(0, MSG_LOGON, VAL_VALID);
		send_msg(0, MSG_APP, VAL_SEQ_HIGH);
		wait_strobe(3, "resend request order");
		send_msg(0, MSG_GAP_FILL, VAL_VALID);
		wait_strobe(2, "sequence update");
		send_msg(0, MSG_SEQ_RESET, VAL_VALID);
		wait_strobe(2, "sequence update");
		send_msg(0, MSG_APP, VAL_VALID);
		drain();
		send_msg(0, MSG_HEARTBEAT, VAL_VALID);
		wait_strobe(3, "heartbeat order");
		end_test("resend_path");

		// back to normal before the garbled message
		send_msg(0, MSG_APP, VAL_VALID);
		drain();
		send_msg(0, MSG_APP, VAL_GARBLED);
		wait_strobe(1, "ignore");
		send_msg(0, MSG_APP, VAL_SEQ_LOW);
		wait_strobe(0, "disconnect");
		send_connect(1);
		send_msg(1, MSG_LOGON, VAL_INVALID);
		wait_strobe(0, "disconnect");
		send_msg(2, MSG_HEARTBEAT, VAL_SEQ_LOW);
		wait_strobe(0, "disconnect");
		end_test("ignore_and_fatal");

		random_mix(2000);
		end_test("random_mix");

		$display("events %0d, checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			chk.events, chk.checks, chk.errors, timeouts, dut.u_assertions.fail_count);
		if (bad_count() == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
design/session_pkg.sv
design/host_table.sv
design/session_table.sv
design/session_fsm.sv
design/session_output.sv
design/session_manager.sv
tests/session_assertions.sv
tests/session_checker.sv
tests/tb_session_manager.sv
